/* common/bus_pkg.sv */
`include "lsu_cfg.svh"

package bus_pkg;

   // one data bus word.
   typedef logic [`LSU_XLEN-1:0] bus_word_t;

   // one select bit per byte lane of the bus word.
   typedef logic [`LSU_XLEN/8-1:0] bus_sel_t;

endpackage

/* common/lsu_cfg.svh */
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// width of the data register and of the bus word.
`define LSU_XLEN 32

// the serial bit counter walks through one data word, so 2**5 = 32 steps.
`define LSU_CNT_W 5

// set to 0 to let misaligned half and word accesses go out on the bus.
`define LSU_WITH_MISALIGN 1

`endif

/* common/lsu_pkg.sv */
package lsu_pkg;

   // operation requested by the command strobe.
   typedef enum logic [1:0] {
      LSU_LOAD  = 2'd0,
      LSU_STORE = 2'd1,
      LSU_SHIFT = 2'd2
   } lsu_op_t;

   // access size of a load or store.
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } lsu_size_t;

   typedef logic [1:0] lsb_t;     // low two address bits, the byte offset.
   typedef logic [1:0] bytecnt_t; // byte index within the serial word.

   // phases of the serial sequencer.
   typedef enum logic [2:0] {
      PH_IDLE = 3'd0, // waiting for a command strobe.
      PH_INIT = 3'd1, // operand shifts in, 32 cycles.
      PH_BUS  = 3'd2, // bus cycle open, waiting for the acknowledge.
      PH_EXEC = 3'd3, // load data shifts out or the shift amount counts down.
      PH_DONE = 3'd4  // one cycle completion pulse.
   } phase_t;

endpackage

/* hdl/bus_data_port.sv */
`timescale 1ns/1ns

module bus_data_port (
   input  logic i_clk,
   input  logic i_rst_n,
   input  logic i_bus_req,
   input  logic i_bus_we,
   input  logic i_wb_ack,
   output logic o_wb_cyc,
   output logic o_wb_we
);

   logic cyc_r;
   logic we_r;

   // the cycle opens one clock after the request and closes on the
   // clock that sees the acknowledge.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cyc_r <= 1'b0;
         we_r  <= 1'b0;
      end else if (cyc_r) begin
         if (i_wb_ack) begin // slave has taken or returned the word.
            cyc_r <= 1'b0;
            we_r  <= 1'b0;
         end
      end else if (i_bus_req) begin
         cyc_r <= 1'b1;
         we_r  <= i_bus_we;  // held until the acknowledge.
      end
      // an acknowledge with no open cycle falls through untouched.
   end

   assign o_wb_cyc = cyc_r;
   assign o_wb_we  = we_r;

endmodule

/* hdl/lsu_sequencer.sv */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module lsu_sequencer (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_cmd_valid,
   input  lsu_pkg::lsu_op_t   i_cmd_op,
   input  lsu_pkg::lsu_size_t i_cmd_size,
   input  logic               i_cmd_signed,
   input  lsu_pkg::lsb_t      i_cmd_lsb,
   input  logic               i_misalign,
   input  logic               i_sh_done,
   input  logic               i_wb_ack,
   output logic               o_en,
   output logic               o_init,
   output logic               o_cnt_done,
   output lsu_pkg::bytecnt_t  o_bytecnt,
   output lsu_pkg::lsb_t      o_lsb,
   output logic               o_word,
   output logic               o_half,
   output logic               o_signed,
   output logic               o_shift_op,
   output logic               o_bus_req,
   output logic               o_bus_we,
   output logic               o_busy,
   output logic               o_done,
   output logic               o_misalign_trap,
   output logic               o_rd_valid,
   output logic               o_shift_active
);

   lsu_pkg::phase_t       state;
   lsu_pkg::phase_t       state_nxt;
   logic [`LSU_CNT_W-1:0] cnt;       // serial bit counter.
   lsu_pkg::lsu_op_t      op_r;
   lsu_pkg::lsu_size_t    size_r;
   logic                  signed_r;
   lsu_pkg::lsb_t         lsb_r;
   logic                  trap_r;
   logic                  accept;
   logic                  last_init;
   logic                  is_mem;

   // a strobe is only taken while idle, later ones are dropped.
   assign accept    = i_cmd_valid & (state == lsu_pkg::PH_IDLE);
   assign o_cnt_done = &cnt;                                   // counter at 31.
   assign last_init = (state == lsu_pkg::PH_INIT) & o_cnt_done;
   assign is_mem    = (op_r != lsu_pkg::LSU_SHIFT);           // load or store.

   always_comb begin
      state_nxt = state;
      case (state)
         lsu_pkg::PH_IDLE: begin
            if (accept) state_nxt = lsu_pkg::PH_INIT;
         end
         lsu_pkg::PH_INIT: begin
            // the misalign flag is only meaningful once init has finished.
            if (o_cnt_done) begin
               if (!is_mem)
                  state_nxt = lsu_pkg::PH_EXEC;
               else if (i_misalign)
                  state_nxt = lsu_pkg::PH_DONE;
               else
                  state_nxt = lsu_pkg::PH_BUS;
            end
         end
         lsu_pkg::PH_BUS: begin
            if (i_wb_ack)
               state_nxt = (op_r == lsu_pkg::LSU_LOAD) ? lsu_pkg::PH_EXEC : lsu_pkg::PH_DONE;
         end
         lsu_pkg::PH_EXEC: begin
            // a shift stops when the countdown wraps, a load after 32 bits.
            if (o_shift_active ? i_sh_done : o_cnt_done) state_nxt = lsu_pkg::PH_DONE;
         end
         lsu_pkg::PH_DONE: state_nxt = lsu_pkg::PH_IDLE;
         default:          state_nxt = lsu_pkg::PH_IDLE;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         state  <= lsu_pkg::PH_IDLE;
         cnt    <= '0;
         op_r   <= lsu_pkg::LSU_LOAD;
         trap_r <= 1'b0;
      end else begin
         state <= state_nxt;
         if (accept) begin
            cnt  <= '0;       // every command starts at bit 0.
            op_r <= i_cmd_op;
         end else if (o_en) begin
            cnt <= cnt + 1'b1; // wraps to 0 at the end of init, ready for execute.
         end
         // high for exactly the done cycle that follows a trapped access.
         trap_r <= last_init & is_mem & i_misalign;
      end
   end

   // the remaining command fields are plain payload.
   always_ff @(posedge i_clk) begin
      if (accept) begin
         size_r   <= i_cmd_size;
         signed_r <= i_cmd_signed;
         lsb_r    <= i_cmd_lsb;
      end
   end

   assign o_en      = (state == lsu_pkg::PH_INIT) | (state == lsu_pkg::PH_EXEC);
   assign o_init    = (state == lsu_pkg::PH_INIT);
   assign o_bytecnt = cnt[`LSU_CNT_W-1 -: 2]; // upper two bits select the byte.
   assign o_lsb     = lsb_r;
   assign o_word    = (size_r == lsu_pkg::SZ_WORD);
   assign o_half    = (size_r == lsu_pkg::SZ_HALF);
   assign o_signed  = signed_r;
   assign o_shift_op = !is_mem;

   // the port turns this one cycle request into the held bus cycle.
   assign o_bus_req = last_init & is_mem & !i_misalign;
   assign o_bus_we  = (op_r == lsu_pkg::LSU_STORE);

   assign o_busy          = (state != lsu_pkg::PH_IDLE);
   assign o_done          = (state == lsu_pkg::PH_DONE);
   assign o_misalign_trap = trap_r;
   assign o_shift_active  = (state == lsu_pkg::PH_EXEC) & o_shift_op;
   assign o_rd_valid      = (state == lsu_pkg::PH_EXEC) & !o_shift_op; // load result bits.

endmodule

/* hdl/serial_lsu_top.sv */
`timescale 1ns/1ns

module serial_lsu_top (
   input  logic               i_clk,
   input  logic               i_rst_n,
   input  logic               i_cmd_valid,
   input  lsu_pkg::lsu_op_t   i_cmd_op,
   input  lsu_pkg::lsu_size_t i_cmd_size,
   input  logic               i_cmd_signed,
   input  lsu_pkg::lsb_t      i_cmd_lsb,
   input  logic               i_op_b,
   input  bus_pkg::bus_word_t i_wb_rdt,
   input  logic               i_wb_ack,
   output logic               o_busy,
   output logic               o_done,
   output logic               o_misalign,
   output logic               o_init,
   output logic               o_rd,
   output logic               o_rd_valid,
   output logic               o_sh_done,
   output logic               o_wb_cyc,
   output logic               o_wb_we,
   output bus_pkg::bus_word_t o_wb_dat,
   output bus_pkg::bus_sel_t  o_wb_sel
);

   logic              en;
   logic              cnt_done;
   lsu_pkg::bytecnt_t bytecnt;
   lsu_pkg::lsb_t     lsb;
   logic              word;
   logic              half;
   logic              sgn;
   logic              shift_op;
   logic              misalign;   // raw offset check from the data register block.
   logic              bus_req;
   logic              bus_we;

   lsu_sequencer u_seq (
      .i_clk           (i_clk),
      .i_rst_n         (i_rst_n),
      .i_cmd_valid     (i_cmd_valid),
      .i_cmd_op        (i_cmd_op),
      .i_cmd_size      (i_cmd_size),
      .i_cmd_signed    (i_cmd_signed),
      .i_cmd_lsb       (i_cmd_lsb),
      .i_misalign      (misalign),
      .i_sh_done       (o_sh_done),
      .i_wb_ack        (i_wb_ack),
      .o_en            (en),
      .o_init          (o_init),
      .o_cnt_done      (cnt_done),
      .o_bytecnt       (bytecnt),
      .o_lsb           (lsb),
      .o_word          (word),
      .o_half          (half),
      .o_signed        (sgn),
      .o_shift_op      (shift_op),
      .o_bus_req       (bus_req),
      .o_bus_we        (bus_we),
      .o_busy          (o_busy),
      .o_done          (o_done),
      .o_misalign_trap (o_misalign),
      .o_rd_valid      (o_rd_valid),
      .o_shift_active  ()           // countdown status is not needed outside.
   );

   serial_mem_if u_mem_if (
      .i_clk      (i_clk),
      .i_en       (en),
      .i_init     (o_init),
      .i_cnt_done (cnt_done),
      .i_bytecnt  (bytecnt),
      .i_lsb      (lsb),
      .i_shift_op (shift_op),
      .i_signed   (sgn),
      .i_word     (word),
      .i_half     (half),
      .i_op_b     (i_op_b),
      .i_wb_rdt   (i_wb_rdt),
      .i_wb_ack   (i_wb_ack),
      .o_misalign (misalign),
      .o_sh_done  (o_sh_done),
      .o_rd       (o_rd),
      .o_wb_dat   (o_wb_dat),
      .o_wb_sel   (o_wb_sel)
   );

   // the acknowledge from outside goes straight to all three blocks.
   bus_data_port u_port (
      .i_clk     (i_clk),
      .i_rst_n   (i_rst_n),
      .i_bus_req (bus_req),
      .i_bus_we  (bus_we),
      .i_wb_ack  (i_wb_ack),
      .o_wb_cyc  (o_wb_cyc),
      .o_wb_we   (o_wb_we)
   );

endmodule

/* mem_if/serial_mem_if.sv */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module serial_mem_if (
   input  logic                i_clk,
   input  logic                i_en,
   input  logic                i_init,
   input  logic                i_cnt_done,
   input  lsu_pkg::bytecnt_t   i_bytecnt,
   input  lsu_pkg::lsb_t       i_lsb,
   input  logic                i_shift_op,
   input  logic                i_signed,
   input  logic                i_word,
   input  logic                i_half,
   input  logic                i_op_b,
   input  bus_pkg::bus_word_t  i_wb_rdt,
   input  logic                i_wb_ack,
   output logic                o_misalign,
   output logic                o_sh_done,
   output logic                o_rd,
   output bus_pkg::bus_word_t  o_wb_dat,
   output bus_pkg::bus_sel_t   o_wb_sel
);

   bus_pkg::bus_word_t dat;       // shared store, load and shift register.
   logic               signbit;   // last valid bit of a load, used for sign extension.
   logic               byte_valid;
   logic               dat_en;
   logic               dat_cur;
   logic               dat_valid;
   logic [5:0]         dat_shamt;
   bus_pkg::bus_sel_t  size_mask;

   // during a store the operand only moves while lsb + bytecnt stays below 4.
   // the bytes that would fall off the top are never shifted in, so the data
   // ends up left aligned by 8*lsb when init is over.
   assign byte_valid = ({1'b0, i_lsb} + {1'b0, i_bytecnt}) < 3'd4;

   assign dat_en = i_en & (i_shift_op | byte_valid);

   // the selected byte sits at bit 8*lsb and shifts down through that tap.
   assign dat_cur = dat[{i_lsb, 3'b000}];

   // bits still inside the access size. beyond them the output is extension.
   assign dat_valid = i_word | (i_bytecnt == 2'b00) | (i_half & !i_bytecnt[1]);

   assign o_rd = dat_valid ? dat_cur : (signbit & i_signed);

   // outside execute of a shift the low six bits simply shift with the rest.
   // at the end of init bit 5 is cleared so only the five bit amount remains.
   always_comb begin
      if (i_shift_op & !i_init)
         dat_shamt = dat[5:0] - 6'd1; // countdown of the shift amount.
      else
         dat_shamt = {dat[6] & !(i_shift_op & i_cnt_done), dat[5:1]};
   end

   // the borrow into bit 5 marks the last countdown step.
   assign o_sh_done = i_en & i_shift_op & !i_init & dat_shamt[5];

   always_ff @(posedge i_clk) begin
      if (i_wb_ack)
         dat <= i_wb_rdt;                                    // load word from the bus.
      else if (dat_en)
         dat <= {i_op_b, dat[`LSU_XLEN-1:7], dat_shamt};     // serial shift right.

      if (i_en & dat_valid)
         signbit <= dat_cur;
   end

   assign o_wb_dat = dat;

   // lanes covered by the access, moved up to the byte offset.
   always_comb begin
      if (i_word)
         size_mask = 4'b1111;
      else if (i_half)
         size_mask = 4'b0011;
      else
         size_mask = 4'b0001;
   end

   assign o_wb_sel = size_mask << i_lsb;

   // a half must sit on an even offset, a word on offset 0.
   // the flag is only looked at after init, when the command fields are settled.
   assign o_misalign = (`LSU_WITH_MISALIGN != 0) &&
                       ((i_lsb[0] & (i_word | i_half)) | (i_lsb[1] & i_word));

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f serial_lsu.f --top-module serial_lsu_tb -o sim_serial_lsu

status=0
./obj_dir/sim_serial_lsu +verilator+error+limit+10 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log || [ "$status" -ne 0 ]; then
   echo "simulation failed, see sim.log"
   exit 1
fi
grep -q '\*\* PASS \*\*' sim.log

/* serial_lsu.f */
+incdir+common
common/lsu_pkg.sv
common/bus_pkg.sv
hdl/lsu_sequencer.sv
mem_if/serial_mem_if.sv
hdl/bus_data_port.sv
hdl/serial_lsu_top.sv
verif/serial_lsu_assert.sv
verif/serial_lsu_tb.sv

/* verif/serial_lsu_assert.sv */
`timescale 1ns/1ns

module serial_lsu_assert (
   input logic             i_clk,
   input logic             i_rst_n,
   input logic             i_cmd_valid,
   input lsu_pkg::lsu_op_t i_cmd_op,
   input logic             i_wb_ack,
   input logic             i_wb_cyc,
   input logic             i_wb_we,
   input logic             i_done,
   input logic             i_busy,
   input logic             i_misalign
);

   int unsigned fail_count = 0; // read by the testbench top.
   logic        store_cmd;      // the command taken last is a store.

   // a strobe counts only while the unit is idle, the same rule the DUT follows.
   always_ff @(posedge i_clk or negedge i_rst_n) begin
      if (!i_rst_n)
         store_cmd <= 1'b0;
      else if (i_cmd_valid && !i_busy)
         store_cmd <= (i_cmd_op == lsu_pkg::LSU_STORE);
   end

   // once open, the bus cycle and its direction hold until the acknowledge.
   cyc_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wb_cyc && !i_wb_ack |=> i_wb_cyc && $stable(i_wb_we))
      else begin fail_count++; $error("bus cycle or write enable changed before acknowledge"); end

   we_store: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wb_cyc |-> (i_wb_we == store_cmd))
      else begin fail_count++; $error("write enable does not match a store"); end

   done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_done |=> !i_done)
      else begin fail_count++; $error("done stayed high for more than one cycle"); end

   // a trapped access finishes at once and never opens a bus cycle.
   misalign_no_bus: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_misalign |-> (i_done && !i_wb_cyc) ##1 !i_wb_cyc)
      else begin fail_count++; $error("misaligned access reached the bus or lacked done"); end

   cyc_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      i_wb_cyc |-> i_busy)
      else begin fail_count++; $error("bus cycle open while the unit is idle"); end

   reset_idle: assert property (@(posedge i_clk)
      !i_rst_n |-> !i_busy && !i_done && !i_wb_cyc && !i_wb_we && !i_misalign)
      else begin fail_count++; $error("outputs not cleared during reset"); end

endmodule

bind serial_lsu_top serial_lsu_assert u_assert (
   .i_clk       (i_clk),
   .i_rst_n     (i_rst_n),
   .i_cmd_valid (i_cmd_valid),
   .i_cmd_op    (i_cmd_op),
   .i_wb_ack    (i_wb_ack),
   .i_wb_cyc    (o_wb_cyc),
   .i_wb_we     (o_wb_we),
   .i_done      (o_done),
   .i_busy      (o_busy),
   .i_misalign  (o_misalign)
);

/* verif/serial_lsu_tb.sv */
`timescale 1ns/1ns
`include "lsu_cfg.svh"

module serial_lsu_tb;

   localparam int N_CMDS     = 200;
   localparam int CMD_CYCLES = 120; // loose bound on one command, ack wait included.
   localparam int CLK_PERIOD = 20;

   logic               i_clk;
   logic               i_rst_n;
   logic               i_cmd_valid;
   lsu_pkg::lsu_op_t   i_cmd_op;
   lsu_pkg::lsu_size_t i_cmd_size;
   logic               i_cmd_signed;
   lsu_pkg::lsb_t      i_cmd_lsb;
   logic               i_op_b;
   bus_pkg::bus_word_t i_wb_rdt;
   logic               i_wb_ack;
   logic               o_busy;
   logic               o_done;
   logic               o_misalign;
   logic               o_init;
   logic               o_rd;
   logic               o_rd_valid;
   logic               o_sh_done;
   logic               o_wb_cyc;
   logic               o_wb_we;
   bus_pkg::bus_word_t o_wb_dat;
   bus_pkg::bus_sel_t  o_wb_sel;

   logic [31:0]        rng;       // xorshift state.
   logic [31:0]        rd_word;   // word the memory model returns on the next read.
   int                 ack_delay; // wait cycles before the memory model acknowledges.
   logic               wr_seen;   // a write was acknowledged for the current command.
   bus_pkg::bus_word_t wr_dat;
   bus_pkg::bus_sel_t  wr_sel;

   serial_lsu_top uut (.*);

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic fail_stop(input string msg);
      $display("%s", msg);
      $display("** FAIL **");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic expect_bit(input string name, input logic exp, input logic act);
      assert (act === exp) else
         fail_stop($sformatf("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act));
   endtask

   task automatic expect_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
      assert (act === exp) else
         fail_stop($sformatf("Error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                             $time, name, exp, act));
   endtask

   // runs one command from its strobe to the cycle after its done pulse.
   // it is entered and left 2 ns after a rising edge.
   task automatic run_cmd(input lsu_pkg::lsu_op_t op, input lsu_pkg::lsu_size_t size,
                          input logic sgn, input lsu_pkg::lsb_t lsb,
                          input logic [31:0] operand, input logic stray);
      int          n;
      int          w;
      logic        mis;
      logic [3:0]  sel;
      logic [31:0] mask;
      logic        exp_rd;
      rng       = xorshift32(rng);
      rd_word   = rng;
      rng       = xorshift32(rng);
      ack_delay = {30'b0, rng[1:0]}; // 0 to 3 wait cycles.
      wr_seen   = 1'b0;
      w   = (size == lsu_pkg::SZ_WORD) ? 32 : (size == lsu_pkg::SZ_HALF) ? 16 : 8;
      sel = ((size == lsu_pkg::SZ_WORD) ? 4'hf : (size == lsu_pkg::SZ_HALF) ? 4'h3 : 4'h1) << lsb;
      // a half needs an even offset, a word offset 0; shifts never trap.
      mis = (`LSU_WITH_MISALIGN != 0) && (op != lsu_pkg::LSU_SHIFT) &&
            (((size == lsu_pkg::SZ_HALF) && lsb[0]) || ((size == lsu_pkg::SZ_WORD) && (lsb != 2'd0)));
      i_cmd_valid  = 1'b1;
      i_cmd_op     = op;
      i_cmd_size   = size;
      i_cmd_signed = sgn;
      i_cmd_lsb    = lsb;
      @(posedge i_clk);
      #2;
      for (n = 0; n < 32; n++) begin
         i_op_b = operand[n]; // operand bit n goes in during init cycle n.
         if (stray && (n == 10)) begin
            // a strobe with other fields while busy, which must be dropped.
            i_cmd_valid = 1'b1;
            if (op == lsu_pkg::LSU_SHIFT)
               i_cmd_op = lsu_pkg::LSU_STORE;
            else
               i_cmd_op = lsu_pkg::LSU_SHIFT;
            i_cmd_signed = !sgn;
            i_cmd_lsb    = lsb ^ 2'b01;
         end else begin
            i_cmd_valid = 1'b0;
         end
         @(negedge i_clk);
         expect_bit("o_init", 1'b1, o_init);
         @(posedge i_clk);
         #2;
      end
      @(negedge i_clk); // first cycle after init.
      expect_bit("o_init", 1'b0, o_init);
      if (mis) begin
         expect_bit("o_misalign", 1'b1, o_misalign);
         expect_bit("o_done", 1'b1, o_done);
         expect_bit("o_wb_cyc", 1'b0, o_wb_cyc);
      end else if (op == lsu_pkg::LSU_SHIFT) begin
         n = 1;
         while (!o_sh_done) begin
            expect_bit("o_rd_valid", 1'b0, o_rd_valid);
            n++;
            if (n > 40)
               fail_stop("the shift countdown never raised o_sh_done");
            @(negedge i_clk);
         end
         // execute spans shamt+1 cycles, shamt being the first five operand bits.
         expect_equal("shift execute cycles", 32'(operand[4:0]) + 32'd1, n);
         @(negedge i_clk);
         expect_bit("o_done", 1'b1, o_done);
      end else begin
         n = 0;
         while (!(o_done || o_rd_valid)) begin
            n++;
            if (n > 16)
               fail_stop("no bus acknowledge ended the memory access");
            @(negedge i_clk);
         end
         if (op == lsu_pkg::LSU_STORE) begin
            expect_bit("o_done", 1'b1, o_done);
            expect_bit("write acknowledged", 1'b1, wr_seen);
            mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
            expect_equal("o_wb_sel", {28'b0, sel}, {28'b0, wr_sel});
            expect_equal("o_wb_dat", (operand << (8 * lsb)) & mask, wr_dat & mask);
         end else begin
            for (n = 0; n < 32; n++) begin
               // bits past the access width repeat its top bit or read as zero.
               exp_rd = (n < w) ? rd_word[8 * lsb + n] : (sgn & rd_word[8 * lsb + w - 1]);
               expect_bit("o_rd_valid", 1'b1, o_rd_valid);
               expect_bit("o_rd", exp_rd, o_rd);
               @(negedge i_clk);
            end
            expect_bit("o_done", 1'b1, o_done);
         end
      end
      @(posedge i_clk);
      #2;
   endtask

   initial begin
      i_clk = 1'b0;
      forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
   end

   // slave side of the data bus, acknowledging after the drawn delay.
   initial begin : memory_model
      forever begin
         @(posedge i_clk);
         #2;
         if (o_wb_cyc) begin
            repeat (ack_delay) begin
               @(posedge i_clk);
               #2;
            end
            i_wb_rdt = rd_word;
            i_wb_ack = 1'b1;
            if (o_wb_we) begin // the write data is steady for the whole cycle.
               wr_dat  = o_wb_dat;
               wr_sel  = o_wb_sel;
               wr_seen = 1'b1;
            end
            @(posedge i_clk);
            #2;
            i_wb_ack = 1'b0;
         end
      end
   end

   // the bound checker counts its failures, which end the run here.
   initial begin
      forever begin
         @(negedge i_clk);
         if (uut.u_assert.fail_count != 0)
            fail_stop("a bound protocol assertion on the DUT failed");
      end
   end

   initial begin
      #(N_CMDS * CMD_CYCLES * CLK_PERIOD);
      fail_stop("the watchdog expired before all commands finished");
   end

   initial begin : stimulus
      int                 i;
      int unsigned        pick;
      logic [31:0]        operand;
      lsu_pkg::lsu_op_t   op;
      lsu_pkg::lsu_size_t size;
      i_rst_n      = 1'b0;
      i_cmd_valid  = 1'b0;
      i_cmd_op     = lsu_pkg::LSU_LOAD;
      i_cmd_size   = lsu_pkg::SZ_BYTE;
      i_cmd_signed = 1'b0;
      i_cmd_lsb    = 2'd0;
      i_op_b       = 1'b0;
      i_wb_rdt     = '0;
      i_wb_ack     = 1'b0;
      rng          = 32'd52159;
      rd_word      = '0;
      ack_delay    = 0;
      wr_seen      = 1'b0;
      repeat (3) @(posedge i_clk);
      #2;
      i_rst_n = 1'b1;
      @(negedge i_clk);
      expect_bit("o_busy", 1'b0, o_busy);
      @(posedge i_clk);
      #2;
      for (i = 0; i < N_CMDS; i++) begin
         rng     = xorshift32(rng);
         operand = rng;
         rng     = xorshift32(rng);
         // the first 72 commands walk every op, size, offset and sign combination.
         pick = (i < 72) ? i : {16'b0, rng[15:0]};
         if (pick % 3 == 0)
            op = lsu_pkg::LSU_LOAD;
         else if (pick % 3 == 1)
            op = lsu_pkg::LSU_STORE;
         else
            op = lsu_pkg::LSU_SHIFT;
         if ((pick / 3) % 3 == 0)
            size = lsu_pkg::SZ_BYTE;
         else if ((pick / 3) % 3 == 1)
            size = lsu_pkg::SZ_HALF;
         else
            size = lsu_pkg::SZ_WORD;
         if (i == 2)
            operand[4:0] = 5'd0;  // shortest countdown.
         if (i == 5)
            operand[4:0] = 5'd31; // longest countdown.
         run_cmd(op, size, ((pick / 36) % 2) != 0, 2'((pick / 9) % 4), operand, (i % 5) == 2);
      end
      $display("** PASS **");
      $finish;
   end

endmodule
